// ==== hw/wb_ic_pkg.sv ====
//==========================================================================
// Wishbone interconnect package
// Bus widths, request and response structs and the FSM state
// encodings shared by the interconnect, its arbiters and the targets
//==========================================================================

package wb_ic_pkg;

	// Byte-addressed bus with 32-bit data
	localparam int WB_ADDR_W = 32;
	localparam int WB_DATA_W = 32;
	localparam int WB_SEL_W  = WB_DATA_W / 8;

	// Masters sharing the memory target
	localparam int N_MASTERS = 3;

	// Master to target
	typedef struct packed {
		logic [WB_ADDR_W-1:0] adr;
		logic [WB_DATA_W-1:0] dat_w;
		logic [WB_SEL_W-1:0]  sel;
		logic                 we;
		logic                 cyc;
		logic                 stb;
	} wb_req_t;

	// Target to master
	typedef struct packed {
		logic [WB_DATA_W-1:0] dat_r;
		logic                 ack;
		logic                 err;
	} wb_rsp_t;

	// Per-master decode state in the interconnect
	typedef enum logic {MST_IDLE, MST_WAIT} mst_state_e;

	// Arbiter state
	typedef enum logic {ARB_IDLE, ARB_GRANTED} arb_state_e;

endpackage

// ==== hw/wb_rr_arbiter.sv ====
//==========================================================================
// Round-robin arbiter
// Grants one requester at a time, starting the search above the last
// granted index, and holds the grant until that request drops
//==========================================================================

`timescale 1ns/10ps

module wb_rr_arbiter #(
	parameter int N_REQ = 3
) (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic [N_REQ-1:0]         req_i,
	output logic                     gnt_o,
	output logic [$clog2(N_REQ)-1:0] gnt_id_o
);
	import wb_ic_pkg::*;

	localparam int ID_W = $clog2(N_REQ);

	arb_state_e       state_q;
	logic [N_REQ-1:0] last_gnt_q;
	logic [ID_W-1:0]  gnt_id_q;
	logic [N_REQ-1:0] above_last;
	logic [N_REQ-1:0] masked_req;
	logic [N_REQ-1:0] pick;

	function automatic logic [ID_W-1:0] onehot_to_id(input logic [N_REQ-1:0] onehot);
		logic [ID_W-1:0] id;
		id = '0;
		for (int i = 0; i < N_REQ; i++) begin
			if (onehot[i]) begin
				id = ID_W'(i);
			end
		end
		return id;
	endfunction

	// Requests strictly above the last grant win first, else lowest index
	always_comb begin
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < N_REQ; i++) begin
			above_last[i] = seen;
			seen = seen | last_gnt_q[i];
		end
		masked_req = req_i & above_last;
		if (|masked_req) begin
			pick = masked_req & (~masked_req + 1'b1);
		end else begin
			pick = req_i & (~req_i + 1'b1);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q    <= ARB_IDLE;
			last_gnt_q <= '0;
			gnt_id_q   <= '0;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (|req_i) begin
						state_q    <= ARB_GRANTED;
						last_gnt_q <= pick;
						gnt_id_q   <= onehot_to_id(pick);
					end
				end
				ARB_GRANTED: begin
					// Release once the owner withdraws
					if (!req_i[gnt_id_q]) begin
						state_q <= ARB_IDLE;
					end
				end
				default: state_q <= ARB_IDLE;
			endcase
		end
	end

	assign gnt_o    = (state_q == ARB_GRANTED);
	assign gnt_id_o = gnt_id_q;

endmodule

// ==== hw/wb_decode_err_slave.sv ====
//==========================================================================
// Decode-error target
// Answers every strobe that misses the address map with a single-cycle
// ERR and no data
//==========================================================================

`timescale 1ns/10ps

module wb_decode_err_slave (
	input  logic               clk,
	input  logic               rstn,
	input  wb_ic_pkg::wb_req_t req_i,
	output wb_ic_pkg::wb_rsp_t rsp_o
);

	logic err_q;
	logic access;

	// A strobe held through the ERR cycle is not answered twice
	assign access = req_i.cyc && req_i.stb && !err_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= access;
		end
	end

	always_comb begin
		rsp_o       = '0;
		rsp_o.err   = err_q;
		// Never an ACK, and read data stays zero
		rsp_o.ack   = 1'b0;
		rsp_o.dat_r = '0;
	end

endmodule

// ==== hw/wb_interconnect_3x1.sv ====
//==========================================================================
// Wishbone interconnect, three masters to one memory target
// Registers each master's decoded target, arbitrates per target in
// round-robin order and routes responses back to the owning master
//==========================================================================

`timescale 1ns/10ps

module wb_interconnect_3x1 #(
	parameter logic [wb_ic_pkg::WB_ADDR_W-1:0] SRAM_BASE  = 'h1000,
	parameter int unsigned                     SRAM_WORDS = 256
) (
	input  logic               clk,
	input  logic               rstn,
	input  wb_ic_pkg::wb_req_t m_req_i [wb_ic_pkg::N_MASTERS],
	output wb_ic_pkg::wb_rsp_t m_rsp_o [wb_ic_pkg::N_MASTERS],
	output wb_ic_pkg::wb_req_t s_req_o,
	input  wb_ic_pkg::wb_rsp_t s_rsp_i
);
	import wb_ic_pkg::*;

	localparam int MID_W  = $clog2(N_MASTERS);
	localparam int N_TGTS = 2;

	// Target indices
	localparam logic TGT_SRAM = 1'b0;
	localparam logic TGT_ERR  = 1'b1;

	// Inclusive upper end of the memory window
	localparam int unsigned          SRAM_BYTES = SRAM_WORDS * WB_SEL_W;
	localparam logic [WB_ADDR_W-1:0] SRAM_LIMIT = SRAM_BASE + WB_ADDR_W'(SRAM_BYTES) - 1'b1;

	mst_state_e       mst_state_q [N_MASTERS];
	logic             mst_tgt_q   [N_MASTERS];
	logic [N_MASTERS-1:0] tgt_req [N_TGTS];
	logic             tgt_gnt     [N_TGTS];
	logic [MID_W-1:0] tgt_gnt_id  [N_TGTS];
	wb_req_t          t_req       [N_TGTS];
	wb_rsp_t          t_rsp       [N_TGTS];

	function automatic logic decode_tgt(input logic [WB_ADDR_W-1:0] adr);
		if (adr >= SRAM_BASE && adr <= SRAM_LIMIT) begin
			return TGT_SRAM;
		end
		return TGT_ERR;
	endfunction

	// Per-master decode FSM
	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int m = 0; m < N_MASTERS; m++) begin
				mst_state_q[m] <= MST_IDLE;
				mst_tgt_q[m]   <= TGT_ERR;
			end
		end else begin
			for (int m = 0; m < N_MASTERS; m++) begin
				case (mst_state_q[m])
					MST_IDLE: begin
						if (m_req_i[m].cyc && m_req_i[m].stb) begin
							mst_state_q[m] <= MST_WAIT;
							mst_tgt_q[m]   <= decode_tgt(m_req_i[m].adr);
						end
					end
					MST_WAIT: begin
						// Done once the master has seen its response
						if (m_rsp_o[m].ack || m_rsp_o[m].err) begin
							mst_state_q[m] <= MST_IDLE;
						end
					end
					default: mst_state_q[m] <= MST_IDLE;
				endcase
			end
		end
	end

	// Request vector per target from the registered selections
	always_comb begin
		for (int t = 0; t < N_TGTS; t++) begin
			for (int m = 0; m < N_MASTERS; m++) begin
				tgt_req[t][m] = (mst_state_q[m] == MST_WAIT) && (mst_tgt_q[m] == 1'(t));
			end
		end
	end

	for (genvar t = 0; t < N_TGTS; t++) begin : g_tgt
		wb_rr_arbiter #(
			.N_REQ (N_MASTERS)
		) i_arb (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (tgt_req[t]),
			.gnt_o    (tgt_gnt[t]),
			.gnt_id_o (tgt_gnt_id[t])
		);

		// Owner's request only while it still waits on this target
		assign t_req[t] = (tgt_gnt[t] && tgt_req[t][tgt_gnt_id[t]]) ?
			m_req_i[tgt_gnt_id[t]] : '0;
	end

	wb_decode_err_slave i_decode_err (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (t_req[TGT_ERR]),
		.rsp_o (t_rsp[TGT_ERR])
	);

	assign s_req_o         = t_req[TGT_SRAM];
	assign t_rsp[TGT_SRAM] = s_rsp_i;

	// Response goes only to the granted owner of the selected target
	always_comb begin
		logic t;
		for (int m = 0; m < N_MASTERS; m++) begin
			t = mst_tgt_q[m];
			if (mst_state_q[m] == MST_WAIT && tgt_gnt[t] && tgt_gnt_id[t] == MID_W'(m)) begin
				m_rsp_o[m] = t_rsp[t];
			end else begin
				m_rsp_o[m] = '0;
			end
		end
	end

endmodule

// ==== hw/wb_sram_slave.sv ====
//==========================================================================
// Wishbone SRAM target
// Word-addressed memory with byte-lane writes, registered read data
// and a single-cycle ACK per strobe
//==========================================================================

`timescale 1ns/10ps

module wb_sram_slave #(
	parameter int unsigned SRAM_WORDS = 256
) (
	input  logic               clk,
	input  logic               rstn,
	input  wb_ic_pkg::wb_req_t req_i,
	output wb_ic_pkg::wb_rsp_t rsp_o
);
	import wb_ic_pkg::*;

	localparam int IDX_W = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

	logic [WB_DATA_W-1:0] mem_q [SRAM_WORDS];
	logic [WB_DATA_W-1:0] rd_data_q;
	logic                 ack_q;
	logic                 access;
	logic [IDX_W-1:0]     word_idx;

	// Byte offset dropped, upper bits wrap onto the depth
	assign word_idx = req_i.adr[IDX_W+1:2];

	// No second access while the previous ACK is out
	assign access = req_i.cyc && req_i.stb && !ack_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			if (req_i.we) begin
				for (int b = 0; b < WB_SEL_W; b++) begin
					if (req_i.sel[b]) begin
						mem_q[word_idx][8*b +: 8] <= req_i.dat_w[8*b +: 8];
					end
				end
			end else begin
				rd_data_q <= mem_q[word_idx];
			end
		end
	end

	always_comb begin
		rsp_o       = '0;
		rsp_o.dat_r = rd_data_q;
		rsp_o.ack   = ack_q;
		rsp_o.err   = 1'b0;
	end

endmodule

// ==== hw/wb_subsys_top.sv ====
//==========================================================================
// Wishbone subsystem top level
// Three master ports sharing one SRAM through the interconnect
//==========================================================================

`timescale 1ns/10ps

module wb_subsys_top #(
	parameter logic [wb_ic_pkg::WB_ADDR_W-1:0] SRAM_BASE  = 'h1000,
	parameter int unsigned                     SRAM_WORDS = 256
) (
	input  logic               clk,
	input  logic               rstn,
	input  wb_ic_pkg::wb_req_t m_req_i [wb_ic_pkg::N_MASTERS],
	output wb_ic_pkg::wb_rsp_t m_rsp_o [wb_ic_pkg::N_MASTERS]
);
	import wb_ic_pkg::*;

	// SRAM target port
	wb_req_t sram_req;
	wb_rsp_t sram_rsp;

	wb_interconnect_3x1 #(
		.SRAM_BASE  (SRAM_BASE),
		.SRAM_WORDS (SRAM_WORDS)
	) i_wb_interconnect (
		.clk     (clk),
		.rstn    (rstn),
		.m_req_i (m_req_i),
		.m_rsp_o (m_rsp_o),
		.s_req_o (sram_req),
		.s_rsp_i (sram_rsp)
	);

	wb_sram_slave #(
		.SRAM_WORDS (SRAM_WORDS)
	) i_wb_sram (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (sram_req),
		.rsp_o (sram_rsp)
	);

endmodule

// ==== testbench/wb_protocol_checker.sv ====
//==========================================================================
// Interconnect protocol checker
// Assertions on SRAM grant exclusivity, quiet responses in reset,
// single-cycle responses and round-robin fairness
//==========================================================================

`timescale 1ns/10ps

module wb_protocol_checker (
	input logic                  clk,
	input logic                  rstn,
	input wb_ic_pkg::wb_req_t    m_req_i [wb_ic_pkg::N_MASTERS],
	input wb_ic_pkg::wb_rsp_t    m_rsp_i [wb_ic_pkg::N_MASTERS],
	input wb_ic_pkg::wb_req_t    s_req_i,
	input wb_ic_pkg::wb_rsp_t    s_rsp_i,
	input wb_ic_pkg::mst_state_e mst_state_i [wb_ic_pkg::N_MASTERS],
	input logic                  mst_tgt_i [wb_ic_pkg::N_MASTERS]
);
	import wb_ic_pkg::*;

	logic [N_MASTERS-1:0] ack_vec;
	logic [N_MASTERS-1:0] sram_src;
	int unsigned          served [N_MASTERS][N_MASTERS];
	int unsigned          fail_count = 0;

	task automatic count_failure(input string what);
		$error("%s", what);
		fail_count++;
	endtask

	// Masters waiting on the SRAM whose request the SRAM currently sees
	always_comb begin
		for (int m = 0; m < N_MASTERS; m++) begin
			ack_vec[m]  = m_rsp_i[m].ack;
			sram_src[m] = (mst_state_i[m] == MST_WAIT) && !mst_tgt_i[m] &&
				(m_req_i[m] == s_req_i);
		end
	end

	// SRAM completions of the other masters while one waits on the SRAM
	always_ff @(posedge clk) begin
		for (int w = 0; w < N_MASTERS; w++) begin
			for (int o = 0; o < N_MASTERS; o++) begin
				if (!rstn || mst_state_i[w] != MST_WAIT || mst_tgt_i[w]) begin
					served[w][o] <= 0;
				end else if (o != w && ack_vec[o]) begin
					served[w][o] <= served[w][o] + 1;
				end
			end
		end
	end

	// The SRAM strobe belongs to exactly one master waiting on the SRAM
	a_one_owner: assert property (@(posedge clk) disable iff (!rstn)
		s_req_i.stb |-> $onehot(sram_src))
		else count_failure("SRAM request does not come from exactly one waiting master");

	// No other master takes the SRAM before the current transfer is acked
	a_owner_held: assert property (@(posedge clk) disable iff (!rstn)
		(s_req_i.stb && !s_rsp_i.ack) |=> (s_req_i.stb && $stable(s_req_i)))
		else count_failure("SRAM request changed before its ack");

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_mst
		a_reset_quiet: assert property (@(posedge clk)
			!rstn |=> !(m_rsp_i[m].ack || m_rsp_i[m].err))
			else count_failure("Response asserted during or right after reset");
		a_single_cycle: assert property (@(posedge clk) disable iff (!rstn)
			(m_rsp_i[m].ack || m_rsp_i[m].err) |=> !(m_rsp_i[m].ack || m_rsp_i[m].err))
			else count_failure("Response held for two cycles");
		for (genvar o = 0; o < N_MASTERS; o++) begin : g_other
			a_fair: assert property (@(posedge clk) disable iff (!rstn) served[m][o] <= 1)
				else count_failure("Master served twice while another waited on the SRAM");
		end
	end

endmodule

// ==== testbench/wb_scoreboard.sv ====
//==========================================================================
// Wishbone subsystem scoreboard
// Byte-lane memory model with a written mask, checks every response
// seen at the master ports
//==========================================================================

`timescale 1ns/10ps

module wb_scoreboard #(
	parameter logic [wb_ic_pkg::WB_ADDR_W-1:0] SRAM_BASE  = 'h1000,
	parameter int unsigned                     SRAM_WORDS = 256
) (
	input  logic               clk,
	input  logic               rstn,
	input  wb_ic_pkg::wb_req_t m_req_i [wb_ic_pkg::N_MASTERS],
	input  wb_ic_pkg::wb_rsp_t m_rsp_i [wb_ic_pkg::N_MASTERS],
	output int unsigned        err_count_o,
	output int unsigned        rsp_count_o
);
	import wb_ic_pkg::*;

	// One past the last byte of the window
	localparam logic [WB_ADDR_W-1:0] SRAM_END = SRAM_BASE + 4 * SRAM_WORDS;

	logic [WB_DATA_W-1:0] mem_model [SRAM_WORDS];
	logic [WB_SEL_W-1:0]  written [SRAM_WORDS];

	task automatic compare(input int m, input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("FAILED at %0t: m_rsp_o[%0d].%s expected %h, got %h",
				$time, m, name, exp, act);
			err_count_o++;
		end
	endtask

	initial begin
		err_count_o = 0;
		rsp_count_o = 0;
		for (int i = 0; i < SRAM_WORDS; i++) begin
			written[i] = '0;
		end
	end

	// Requests and responses are both stable at the rising edge
	always @(posedge clk) begin
		wb_req_t              req;
		logic                 in_win;
		int unsigned          idx;
		logic [WB_DATA_W-1:0] exp_data;
		logic [WB_DATA_W-1:0] mask;
		for (int m = 0; m < N_MASTERS; m++) begin
			req = m_req_i[m];
			if (rstn && (m_rsp_i[m].ack || m_rsp_i[m].err)) begin
				rsp_count_o++;
				in_win   = (req.adr >= SRAM_BASE) && (req.adr < SRAM_END);
				idx      = (req.adr >> 2) % SRAM_WORDS;
				exp_data = '0;
				mask     = in_win ? '0 : '1;
				if (!(req.cyc && req.stb)) begin
					$display("Master %0d got a response at %0t with no strobe raised", m, $time);
					err_count_o++;
				end
				for (int b = 0; b < WB_SEL_W; b++) begin
					if (in_win && req.we && req.sel[b]) begin
						mem_model[idx][8*b +: 8] = req.dat_w[8*b +: 8];
						written[idx][b] = 1'b1;
					end else if (in_win && !req.we && written[idx][b]) begin
						exp_data[8*b +: 8] = mem_model[idx][8*b +: 8];
						mask[8*b +: 8]     = 8'hff;
					end
				end
				compare(m, "ack", 32'(in_win), 32'(m_rsp_i[m].ack));
				compare(m, "err", 32'(!in_win), 32'(m_rsp_i[m].err));
				compare(m, "dat_r", exp_data & mask, m_rsp_i[m].dat_r & mask);
			end
		end
	end

endmodule

// ==== testbench/tb_wb_subsys.sv ====
//==========================================================================
// Wishbone subsystem testbench
// Three random masters against the SRAM window and the decode-error
// space, with a scoreboard, bound assertions and a cycle limit
//==========================================================================

`timescale 1ns/10ps

module tb_wb_subsys;
	import wb_ic_pkg::*;

	localparam logic [WB_ADDR_W-1:0] SRAM_BASE  = 'h1000;
	localparam int unsigned          SRAM_WORDS = 256;
	localparam int                   N_TRANS    = 200;
	localparam logic [31:0]          SEED       = 32'h1771;
	// Latency, release and idle allowance per transaction
	localparam int MAX_CYCLES = N_MASTERS * N_TRANS * (3 + 3 + 4) + 200;

	logic        clk;
	logic        rstn;
	wb_req_t     m_req [N_MASTERS];
	wb_rsp_t     m_rsp [N_MASTERS];
	int unsigned sb_errors;
	int unsigned sb_rsps;
	int unsigned chk_errors;
	int unsigned tb_errors;
	int unsigned cycles;

	always #4 clk = ~clk;

	wb_subsys_top #(
		.SRAM_BASE  (SRAM_BASE),
		.SRAM_WORDS (SRAM_WORDS)
	) i_wb_subsys_top (
		.clk     (clk),
		.rstn    (rstn),
		.m_req_i (m_req),
		.m_rsp_o (m_rsp)
	);

	wb_scoreboard #(
		.SRAM_BASE  (SRAM_BASE),
		.SRAM_WORDS (SRAM_WORDS)
	) i_scoreboard (
		.clk         (clk),
		.rstn        (rstn),
		.m_req_i     (m_req),
		.m_rsp_i     (m_rsp),
		.err_count_o (sb_errors),
		.rsp_count_o (sb_rsps)
	);

	bind wb_interconnect_3x1 wb_protocol_checker i_protocol_checker (
		.clk         (clk),
		.rstn        (rstn),
		.m_req_i     (m_req_i),
		.m_rsp_i     (m_rsp_o),
		.s_req_i     (s_req_o),
		.s_rsp_i     (s_rsp_i),
		.mst_state_i (mst_state_q),
		.mst_tgt_i   (mst_tgt_q)
	);

	task automatic run_master(input int m);
		int          seed;
		logic [31:0] r;
		logic [31:0] pick;
		wb_req_t     req;
		seed = SEED + m;
		for (int n = 0; n < N_TRANS; n++) begin
			r         = $random(seed);
			pick      = $random(seed);
			req       = '0;
			req.cyc   = 1'b1;
			req.stb   = 1'b1;
			req.we    = r[0];
			req.sel   = r[0] ? r[7:4] : '1;
			req.dat_w = $random(seed);
			if (r[31:16] % 100 < 90) begin
				req.adr = SRAM_BASE + 4 * (pick % SRAM_WORDS);
			end else if (r[1]) begin
				req.adr = 4 * (pick % (SRAM_BASE / 4));
			end else begin
				// At or beyond the end of the window
				req.adr = SRAM_BASE + 4 * SRAM_WORDS + 4 * (pick % 1024);
			end
			@(negedge clk);
			m_req[m] = req;
			do begin
				@(negedge clk);
			end while (!(m_rsp[m].ack || m_rsp[m].err));
			@(negedge clk);
			m_req[m] = '0;
			repeat (r[9:8]) @(negedge clk);
		end
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: masters did not finish within %0d cycles", MAX_CYCLES);
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		clk       = 1'b0;
		rstn      = 1'b0;
		tb_errors = 0;
		cycles    = 0;
		for (int m = 0; m < N_MASTERS; m++) begin
			m_req[m] = '0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		fork
			run_master(0);
			run_master(1);
			run_master(2);
		join
		repeat (2) @(negedge clk);
		chk_errors = i_wb_subsys_top.i_wb_interconnect.i_protocol_checker.fail_count;
		if (sb_rsps != N_MASTERS * N_TRANS) begin
			$display("Saw %0d responses for %0d transactions", sb_rsps, N_MASTERS * N_TRANS);
			tb_errors++;
		end
		$display("Error counts: scoreboard %0d, assertions %0d, testbench %0d",
			sb_errors, chk_errors, tb_errors);
		if (sb_errors + chk_errors + tb_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
hw/wb_ic_pkg.sv
hw/wb_rr_arbiter.sv
hw/wb_decode_err_slave.sv
hw/wb_interconnect_3x1.sv
hw/wb_sram_slave.sv
hw/wb_subsys_top.sv
testbench/wb_protocol_checker.sv
testbench/wb_scoreboard.sv
testbench/tb_wb_subsys.sv

// ==== Bender.yml ====
package:
  name: wb_subsys

sources:
  - hw/wb_ic_pkg.sv
  - hw/wb_rr_arbiter.sv
  - hw/wb_decode_err_slave.sv
  - hw/wb_interconnect_3x1.sv
  - hw/wb_sram_slave.sv
  - hw/wb_subsys_top.sv
  - target: test
    files:
      - testbench/wb_protocol_checker.sv
      - testbench/wb_scoreboard.sv
      - testbench/tb_wb_subsys.sv
